//--- logic/host_mon_pkg.sv
/*
 * host_mon package
 * Widths, the two-rule address map and the event types of the traffic monitor
 */
`default_nettype none

package host_mon_pkg;

  localparam int unsigned ADDR_W = 64;
  typedef logic [ADDR_W-1:0] addr_t;

  // Address map with exclusive rule ends
  localparam int unsigned NUM_RULES = 2;
  localparam addr_t DEBUG_BASE = '0;
  localparam addr_t HYAXI_BASE = addr_t'(32'h8000_0000);
  localparam addr_t HYAXI_LEN  = addr_t'(32'h4000_0000);

  typedef logic [$clog2(NUM_RULES)-1:0] region_t;

  // Event index is region * 4 + kind
  // Kind 0 read miss, 1 read hit, 2 write miss, 3 write hit
  localparam int unsigned NUM_EVENTS = 8;
  typedef logic [NUM_EVENTS-1:0] event_vec_t;
  typedef logic [$clog2(NUM_EVENTS)-1:0] event_idx_t;

endpackage

`default_nettype wire

//--- logic/mon_req_if.sv
/*
 * Decoded request between the rule decoder and the event generator
 */
`timescale 1ns/1ps
`default_nettype none

interface mon_req_if;

  // One-cycle strobe without acknowledge
  logic                  valid;
  host_mon_pkg::region_t region;
  logic                  mapped;
  logic                  write;
  logic                  hit;

  modport src (
    output valid, region, mapped, write, hit
  );

  modport dst (
    input valid, region, mapped, write, hit
  );

endinterface

`default_nettype wire

//--- logic/mem_rule_decode.sv
/*
 * Memory rule decoder
 * Registers each request and matches its address against the debug and hyperbus rules
 */
`timescale 1ns/1ps
`default_nettype none

module mem_rule_decode (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                req_valid_i,
  input  host_mon_pkg::addr_t req_addr_i,
  input  logic                req_write_i,
  input  logic                req_hit_i,
  mon_req_if.src              out
);

  localparam host_mon_pkg::addr_t RULE_START [host_mon_pkg::NUM_RULES] = '{
    host_mon_pkg::DEBUG_BASE,
    host_mon_pkg::HYAXI_BASE
  };
  localparam host_mon_pkg::addr_t RULE_END [host_mon_pkg::NUM_RULES] = '{
    host_mon_pkg::HYAXI_BASE,
    host_mon_pkg::HYAXI_BASE + host_mon_pkg::HYAXI_LEN
  };

  logic [host_mon_pkg::NUM_RULES-1:0] rule_hit;
  host_mon_pkg::region_t              hit_region;

  always_comb begin
    rule_hit   = '0;
    hit_region = '0;
    for (int i = 0; i < host_mon_pkg::NUM_RULES; i++) begin
      if (req_addr_i >= RULE_START[i] && req_addr_i < RULE_END[i]) begin
        rule_hit[i] = 1'b1;
        hit_region  = host_mon_pkg::region_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= req_valid_i;
    end
  end

  // Only meaningful while valid is set
  always_ff @(posedge clk_i) begin
    out.region <= hit_region;
    out.mapped <= |rule_hit;
    out.write  <= req_write_i;
    out.hit    <= req_hit_i;
  end

  // Address map regions must not overlap
  rule_overlap_a : assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i |-> $onehot0(rule_hit));

endmodule

`default_nettype wire

//--- logic/traffic_event_gen.sv
/*
 * Traffic event generator
 * Turns a decoded request into a registered one-hot event vector
 */
`timescale 1ns/1ps
`default_nettype none

module traffic_event_gen (
  input  logic                     clk_i,
  input  logic                     reset_i,
  mon_req_if.dst                   in,
  output logic                     event_valid_o,
  output host_mon_pkg::event_vec_t event_vec_o
);

  host_mon_pkg::event_idx_t ev_idx;
  logic                     ev_fire;

  // Region in the top bit, then write and hit as the kind
  assign ev_idx  = {in.region, in.write, in.hit};
  assign ev_fire = in.valid && in.mapped;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      event_valid_o <= 1'b0;
    end else begin
      event_valid_o <= ev_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ev_fire) begin
      event_vec_o <= host_mon_pkg::event_vec_t'(1) << ev_idx;
    end else begin
      event_vec_o <= '0;
    end
  end

endmodule

`default_nettype wire

//--- logic/event_counter_bank.sv
/*
 * Event counter bank
 * Saturating per-event counters with sticky watermark interrupts, clear and read port
 */
`timescale 1ns/1ps
`default_nettype none

module event_counter_bank #(
  parameter int unsigned CntWidth = 16
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     event_valid_i,
  input  host_mon_pkg::event_vec_t event_vec_i,
  input  logic                     clear_i,
  input  logic [CntWidth-1:0]      threshold_i,
  input  host_mon_pkg::event_idx_t rd_idx_i,
  output logic [CntWidth-1:0]      rd_count_o,
  output host_mon_pkg::event_vec_t irq_o
);

  localparam logic [CntWidth-1:0] CNT_MAX = '1;

  logic [CntWidth-1:0]      cnt_q [host_mon_pkg::NUM_EVENTS];
  logic [CntWidth-1:0]      cnt_d [host_mon_pkg::NUM_EVENTS];
  host_mon_pkg::event_vec_t irq_q;
  host_mon_pkg::event_vec_t irq_d;
  host_mon_pkg::event_vec_t bump;

  assign bump = event_valid_i ? event_vec_i : '0;

  always_comb begin
    for (int i = 0; i < host_mon_pkg::NUM_EVENTS; i++) begin
      cnt_d[i] = cnt_q[i];
      irq_d[i] = irq_q[i];
      if (bump[i]) begin
        // Hold at the top once saturated
        if (cnt_q[i] != CNT_MAX) begin
          cnt_d[i] = cnt_q[i] + 1'b1;
        end
        if (cnt_d[i] >= threshold_i) begin
          irq_d[i] = 1'b1;
        end
      end
    end
  end

  // Clear wins over an event arriving on the same edge
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      for (int i = 0; i < host_mon_pkg::NUM_EVENTS; i++) begin
        cnt_q[i] <= '0;
      end
      irq_q <= '0;
    end else begin
      for (int i = 0; i < host_mon_pkg::NUM_EVENTS; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
      irq_q <= irq_d;
    end
  end

  assign rd_count_o = cnt_q[rd_idx_i];
  assign irq_o      = irq_q;

  // Generator must never flag two events for one request
  event_onehot_a : assert property (@(posedge clk_i) disable iff (reset_i)
    event_valid_i |-> $onehot0(event_vec_i));

endmodule

`default_nettype wire

//--- logic/host_mon_top.sv
/*
 * host_mon top level
 * Decode, event generation and counting of host memory traffic in three stages
 */
`timescale 1ns/1ps
`default_nettype none

module host_mon_top #(
  parameter int unsigned CntWidth = 16
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_valid_i,
  input  host_mon_pkg::addr_t      req_addr_i,
  input  logic                     req_write_i,
  input  logic                     req_hit_i,
  input  logic                     clear_i,
  input  logic [CntWidth-1:0]      threshold_i,
  input  host_mon_pkg::event_idx_t rd_idx_i,
  output logic [CntWidth-1:0]      rd_count_o,
  output host_mon_pkg::event_vec_t irq_o
);

  mon_req_if req_if ();

  logic                     event_valid;
  host_mon_pkg::event_vec_t event_vec;

  mem_rule_decode i_mem_rule_decode (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .req_valid_i ( req_valid_i  ),
    .req_addr_i  ( req_addr_i   ),
    .req_write_i ( req_write_i  ),
    .req_hit_i   ( req_hit_i    ),
    .out         ( req_if.src   )
  );

  traffic_event_gen i_traffic_event_gen (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .in            ( req_if.dst  ),
    .event_valid_o ( event_valid ),
    .event_vec_o   ( event_vec   )
  );

  event_counter_bank #(
    .CntWidth ( CntWidth )
  ) i_event_counter_bank (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .event_valid_i ( event_valid ),
    .event_vec_i   ( event_vec   ),
    .clear_i       ( clear_i     ),
    .threshold_i   ( threshold_i ),
    .rd_idx_i      ( rd_idx_i    ),
    .rd_count_o    ( rd_count_o  ),
    .irq_o         ( irq_o       )
  );

endmodule

`default_nettype wire

//--- sim/host_mon_tb.sv
/*
 * host_mon testbench
 * Random host traffic checked against a model of the event counters
 */
`timescale 1ns/1ps
`default_nettype none

module host_mon_tb;

  localparam int CNT_W = 4;
  localparam int WAIT_LIMIT = 64;
  localparam int unsigned SEED = 32'ha8b0_a3e5;

  typedef logic [CNT_W-1:0] count_t;

  logic                     clk;
  logic                     reset;
  logic                     req_valid;
  host_mon_pkg::addr_t      req_addr;
  logic                     req_write;
  logic                     req_hit;
  logic                     clear;
  count_t                   threshold;
  host_mon_pkg::event_idx_t rd_idx;
  count_t                   rd_count;
  host_mon_pkg::event_vec_t irq;

  // Reference model state
  count_t                   model_cnt [8];
  host_mon_pkg::event_vec_t model_irq;
  count_t                   model_thr;

  int errors;
  int test_errs;
  int tests_run;
  int tests_failed;
  int sat_idx;

  host_mon_top #(
    .CntWidth ( CNT_W )
  ) dut0 (
    .clk_i       ( clk       ),
    .reset_i     ( reset     ),
    .req_valid_i ( req_valid ),
    .req_addr_i  ( req_addr  ),
    .req_write_i ( req_write ),
    .req_hit_i   ( req_hit   ),
    .clear_i     ( clear     ),
    .threshold_i ( threshold ),
    .rd_idx_i    ( rd_idx    ),
    .rd_count_o  ( rd_count  ),
    .irq_o       ( irq       )
  );

  always #20 clk = ~clk;

  task automatic check_count(input count_t got, input count_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED @ %0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic check_irq(input host_mon_pkg::event_vec_t got,
                           input host_mon_pkg::event_vec_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED @ %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic wait_edges(input int n);
    int seen;
    seen = 0;
    while (seen < n && seen < WAIT_LIMIT) begin
      @(posedge clk);
      seen++;
    end
    if (seen < n) begin
      $display("Timeout while waiting for the pipeline to drain at %0t", $time);
      errors++;
      test_errs++;
    end
  endtask

  // Region 0 runs up to the hyperbus base and region 1 covers the hyperbus window
  function automatic bit decode_region(input host_mon_pkg::addr_t addr, output bit region);
    region = 1'b0;
    if (addr < host_mon_pkg::HYAXI_BASE) begin
      return 1'b1;
    end
    region = 1'b1;
    return addr < host_mon_pkg::HYAXI_BASE + host_mon_pkg::HYAXI_LEN;
  endfunction

  task automatic model_event(input host_mon_pkg::addr_t addr, input bit write, input bit hit);
    bit region;
    int idx;
    if (decode_region(addr, region)) begin
      idx = int'(region) * 4 + int'(write) * 2 + int'(hit);
      if (model_cnt[idx] != 4'd15) begin
        model_cnt[idx] = model_cnt[idx] + 1'b1;
      end
      if (model_cnt[idx] >= model_thr) begin
        model_irq[idx] = 1'b1;
      end
    end
  endtask

  function automatic host_mon_pkg::addr_t rand_addr(input int sel);
    case (sel)
      0: rand_addr = host_mon_pkg::addr_t'($urandom & 32'h7fff_ffff);
      1: rand_addr = 64'h8000_0000 + host_mon_pkg::addr_t'($urandom & 32'h3fff_ffff);
      default: begin
        if ($urandom_range(1) == 0) begin
          rand_addr = 64'hC000_0000 + host_mon_pkg::addr_t'($urandom & 32'h3fff_ffff);
        end else begin
          rand_addr = {$urandom | 32'h1, $urandom};
        end
      end
    endcase
  endfunction

  task automatic drive_req(input bit valid, input host_mon_pkg::addr_t addr,
                           input bit write, input bit hit);
    @(posedge clk);
    req_valid <= valid;
    req_addr  <= addr;
    req_write <= write;
    req_hit   <= hit;
    if (valid) begin
      model_event(addr, write, hit);
    end
  endtask

  task automatic drain;
    drive_req(1'b0, '0, 1'b0, 1'b0);
    wait_edges(2);
  endtask

  task automatic run_traffic(input int cycles, input bit unmapped_only);
    int sel;
    bit idle;
    for (int c = 0; c < cycles; c++) begin
      idle = ($urandom_range(3) == 0);
      sel = unmapped_only ? 2 : int'($urandom_range(1));
      drive_req(!idle, rand_addr(sel), 1'($urandom), 1'($urandom));
    end
    drain();
  endtask

  task automatic check_all(input string tag);
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      rd_idx <= host_mon_pkg::event_idx_t'(i);
      @(negedge clk);
      check_count(rd_count, model_cnt[i], $sformatf("%s count %0d", tag, i));
    end
    check_irq(irq, model_irq, {tag, " irq"});
  endtask

  task automatic pulse_clear;
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    for (int i = 0; i < 8; i++) begin
      model_cnt[i] = '0;
    end
    model_irq = '0;
  endtask

  task automatic set_threshold(input count_t thr);
    @(posedge clk);
    threshold <= thr;
    model_thr = thr;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("Test %0d %s: PASS", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL (%0d errors)", tests_run, name, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    void'($urandom(SEED));
    clk = 1'b0;
    reset = 1'b1;
    req_valid = 1'b0;
    req_addr = '0;
    req_write = 1'b0;
    req_hit = 1'b0;
    clear = 1'b0;
    threshold = 4'd15;
    rd_idx = '0;
    model_thr = 4'd15;
    model_irq = '0;
    for (int i = 0; i < 8; i++) begin
      model_cnt[i] = '0;
    end
    errors = 0;
    test_errs = 0;
    tests_run = 0;
    tests_failed = 0;

    repeat (8) @(posedge clk);
    reset <= 1'b0;

    check_all("reset");
    check_irq(irq, '0, "irq after reset");
    end_test("reset state");

    run_traffic(150, 1'b0);
    check_all("mix");
    end_test("random mapped mix");

    run_traffic(60, 1'b1);
    check_all("unmapped");
    end_test("unmapped dropped");

    pulse_clear();
    set_threshold(count_t'($urandom_range(12, 1)));
    $display("Threshold set to %0d", model_thr);
    run_traffic(80, 1'b0);
    check_all("threshold");
    end_test("sticky watermark irq");

    // Hammer one counter well past its maximum
    sat_idx = int'($urandom_range(7));
    repeat (20) drive_req(1'b1, rand_addr(sat_idx / 4), 1'(sat_idx >> 1), 1'(sat_idx));
    drain();
    @(posedge clk);
    rd_idx <= host_mon_pkg::event_idx_t'(sat_idx);
    @(negedge clk);
    check_count(rd_count, 4'd15, $sformatf("saturated count %0d", sat_idx));
    check_all("saturate");
    end_test("counter saturation");

    pulse_clear();
    check_all("clear");
    check_irq(irq, '0, "irq after clear");
    run_traffic(40, 1'b0);
    check_all("after clear");
    end_test("clear and recount");

    $display("Tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- host_mon.f
logic/host_mon_pkg.sv
logic/mon_req_if.sv
logic/mem_rule_decode.sv
logic/traffic_event_gen.sv
logic/event_counter_bank.sv
logic/host_mon_top.sv
sim/host_mon_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = host_mon_tb
RTL_TOP  = host_mon_top
FILELIST = host_mon.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
